// ==== sim.f ====
verilog/regfile_pkg.sv
verilog/gpr_bank.sv
verilog/mmx_bank.sv
verilog/read_merge.sv
verilog/regfile_top.sv
verif/regfile_chk.sv
verif/regfile_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module regfile_tb -f sim.f -o regfile_sim

# the log decides the result, so a nonzero exit from the model is not fatal here
./obj_dir/regfile_sim +verilator+error+limit+10000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"

// ==== verif/regfile_tb.sv ====
`timescale 1ns/1ps

module regfile_tb import regfile_pkg::*; ();

    localparam int RST_CYCLES  = 8;
    localparam int RAND_OPS    = 400;
    localparam int PLANNED_OPS = RST_CYCLES + 8 * NUM_REGS + 48 + RAND_OPS;  // sweeps, directed
    localparam int WATCHDOG_NS = (PLANNED_OPS + 50) * 40;

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic        clr = 1'b0;
    logic        ld_en = 1'b0;
    op_size_t    ld_size = size_8;
    reg_addr_t   ld_addr = '0;
    mmx_word_t   ld_data = '0;
    logic        dest_en = 1'b0;
    op_size_t    dest_size = size_8;
    reg_addr_t   dest_addr = '0;
    tag_t        new_tag = '0;
    tag_t        done_tag = '0;
    op_size_t    rd_size = size_8;
    reg_addr_t   rd_addr = '0;
    mmx_word_t   rd_data;
    logic        rd_pending;
    logic [31:0] lfsr_state = 32'h5783_efaf;
    tag_t        next_tag = '0;
    tag_t        open_tags [$];
    tag_t        t1;
    tag_t        t2;
    int          ops_done = 0;
    int          errors;

    regfile_top u_dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ({1'b0, s[31:1]} ^ 32'h8020_0003) : {1'b0, s[31:1]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic tag_t alloc_tag();
        next_tag = (next_tag == 7'd127) ? 7'd1 : next_tag + 7'd1;  // 0 is the idle done_tag
        return next_tag;
    endfunction

    task automatic next_cycle();
        @(negedge clk);
        ld_en    = 1'b0;
        dest_en  = 1'b0;
        clr      = 1'b0;
        done_tag = '0;
        ops_done++;
    endtask

    task automatic load(input op_size_t size, input reg_addr_t addr, input mmx_word_t data);
        next_cycle();
        ld_en   = 1'b1;
        ld_size = size;
        ld_addr = addr;
        ld_data = data;
    endtask

    task automatic mark_dest(input op_size_t size, input reg_addr_t addr, input tag_t tag);
        next_cycle();
        dest_en   = 1'b1;
        dest_size = size;
        dest_addr = addr;
        new_tag   = tag;
    endtask

    task automatic read(input op_size_t size, input reg_addr_t addr);
        next_cycle();
        rd_size = size;
        rd_addr = addr;
    endtask

    task automatic sweep_reads();
        for (int s = 0; s < 4; s++) begin
            for (int a = 0; a < NUM_REGS; a++) read(op_size_t'(s[1:0]), a[2:0]);
        end
    endtask

    task automatic random_cycle();
        logic [63:0] r;
        next_cycle();
        r         = rand_bits(18);
        rd_size   = op_size_t'(r[1:0]);
        rd_addr   = r[4:2];
        ld_en     = r[5];
        ld_size   = op_size_t'(r[7:6]);
        ld_addr   = r[10:8];
        ld_data   = rand_bits(64);
        dest_en   = r[11];
        dest_size = op_size_t'(r[13:12]);
        dest_addr = r[16:14];
        if (dest_en) begin
            new_tag = alloc_tag();
            open_tags.push_back(new_tag);
        end
        if (r[17] && open_tags.size() > 0) done_tag = open_tags.pop_front();
    endtask

    initial begin
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        sweep_reads();

        load(size_32, 3'd2, 64'h0123_4567_89ab_cdef);
        read(size_8, 3'd2);
        read(size_8, 3'd6);  // dh
        read(size_16, 3'd2);
        read(size_32, 3'd2);

        load(size_32, 3'd1, 64'h0000_0000_a1b2_c3d4);
        load(size_8, 3'd5, 64'h0000_0000_0000_00ee);  // ch only
        read(size_32, 3'd1);
        load(size_16, 3'd1, 64'h0000_0000_0000_5a5a);
        read(size_32, 3'd1);

        // same index, different banks
        load(size_64, 3'd2, 64'hfeed_face_dead_beef);
        read(size_32, 3'd2);
        load(size_32, 3'd4, 64'h0000_0000_7777_8888);
        read(size_64, 3'd4);
        read(size_64, 3'd2);

        t1 = alloc_tag();
        mark_dest(size_8, 3'd7, t1);  // bh
        read(size_8, 3'd3);
        read(size_16, 3'd3);
        read(size_32, 3'd3);
        complete_tag: begin
            next_cycle();
            done_tag = t1;
        end
        read(size_32, 3'd3);

        t1 = alloc_tag();
        mark_dest(size_32, 3'd0, t1);
        t2 = alloc_tag();
        mark_dest(size_32, 3'd0, t2);
        done_tag = t1;  // completion collides with the new allocation
        read(size_32, 3'd0);
        next_cycle();
        done_tag = t2;
        read(size_32, 3'd0);

        mark_dest(size_64, 3'd5, alloc_tag());
        read(size_64, 3'd5);
        read(size_32, 3'd5);

        next_cycle();
        clr = 1'b1;  // data and the open mm5 mark both go
        sweep_reads();

        repeat (RAND_OPS) random_cycle();
        next_cycle();
        next_cycle();

        errors = u_dut.u_chk.err_cnt;
        $display("%0d cycles driven, %0d assertion errors", ops_done, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the stimulus never reached its end", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== verif/regfile_chk.sv ====
`timescale 1ns/1ps

module regfile_chk import regfile_pkg::*; (
    input logic      clk,
    input logic      arst_n,
    input logic      clr,
    input logic      ld_en,
    input op_size_t  ld_size,
    input reg_addr_t ld_addr,
    input mmx_word_t ld_data,
    input logic      dest_en,
    input op_size_t  dest_size,
    input reg_addr_t dest_addr,
    input tag_t      new_tag,
    input tag_t      done_tag,
    input op_size_t  rd_size,
    input reg_addr_t rd_addr,
    input mmx_word_t rd_data,
    input logic      rd_pending
);

    // sections {e, h, l} touched by an operand
    function automatic logic [2:0] lanes(input op_size_t size, input reg_addr_t addr);
        case (size)
            size_8:  return addr[2] ? 3'b010 : 3'b001;
            size_16: return 3'b011;
            size_32: return 3'b111;
            default: return 3'b000;
        endcase
    endfunction

    function automatic reg_addr_t reg_of(input op_size_t size, input reg_addr_t addr);
        return (size == size_8) ? {1'b0, addr[1:0]} : addr;  // ah..bh live in regs 0-3
    endfunction

    int                  err_cnt = 0;
    gpr_word_t           m_gpr   [NUM_REGS];
    logic [2:0]          m_gpend [NUM_REGS];
    tag_t                m_gtag  [NUM_REGS][3];
    mmx_word_t           m_mmx   [NUM_REGS];
    logic [NUM_REGS-1:0] m_mpend;
    tag_t                m_mtag  [NUM_REGS];
    logic [2:0]          ld_lanes;
    logic [2:0]          dest_lanes;
    gpr_word_t           ld_word;
    gpr_word_t           rd_word;
    mmx_word_t           exp_data;
    logic                exp_pend;

    assign ld_lanes   = ld_en ? lanes(ld_size, ld_addr) : 3'b000;
    assign dest_lanes = dest_en ? lanes(dest_size, dest_addr) : 3'b000;

    always_comb begin
        ld_word = m_gpr[reg_of(ld_size, ld_addr)];
        if (ld_lanes[0]) ld_word[7:0] = ld_data[7:0];
        if (ld_lanes[1]) ld_word[15:8] = (ld_size == size_8) ? ld_data[7:0] : ld_data[15:8];
        if (ld_lanes[2]) ld_word[31:16] = ld_data[31:16];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n || clr) begin
            m_mpend <= '0;
            for (int r = 0; r < NUM_REGS; r++) begin
                m_gpr[r]   <= '0;
                m_gpend[r] <= '0;
                m_mmx[r]   <= '0;
                m_mtag[r]  <= '0;
                for (int s = 0; s < 3; s++) m_gtag[r][s] <= '0;
            end
        end else begin
            m_gpr[reg_of(ld_size, ld_addr)] <= ld_word;  // unchanged when no lane hit
            if (ld_en && ld_size == size_64) m_mmx[ld_addr] <= ld_data;
            for (int r = 0; r < NUM_REGS; r++) begin
                for (int s = 0; s < 3; s++) begin
                    if (dest_lanes[s] && reg_of(dest_size, dest_addr) == reg_addr_t'(r)) begin
                        m_gpend[r][s] <= 1'b1;
                        m_gtag[r][s]  <= new_tag;
                    end else if (m_gtag[r][s] == done_tag) begin
                        m_gpend[r][s] <= 1'b0;
                    end
                end
                if (dest_en && dest_size == size_64 && dest_addr == reg_addr_t'(r)) begin
                    m_mpend[r] <= 1'b1;
                    m_mtag[r]  <= new_tag;
                end else if (m_mtag[r] == done_tag) begin
                    m_mpend[r] <= 1'b0;
                end
            end
        end
    end

    assign rd_word = m_gpr[reg_of(rd_size, rd_addr)];

    always_comb begin
        case (rd_size)
            size_8:  exp_data = {56'h0, (rd_addr[2] ? rd_word[15:8] : rd_word[7:0])};
            size_16: exp_data = {48'h0, rd_word[15:0]};
            size_32: exp_data = {32'h0, rd_word};
            default: exp_data = m_mmx[rd_addr];
        endcase
        if (rd_size == size_64) exp_pend = m_mpend[rd_addr];
        else exp_pend = |(m_gpend[reg_of(rd_size, rd_addr)] & lanes(rd_size, rd_addr));
    end

    a_rd_data: assert property (@(posedge clk) disable iff (!arst_n) rd_data == exp_data)
        else begin
            err_cnt++;
            $error("FAIL rd_data got %h expected %h", $sampled(rd_data), $sampled(exp_data));
        end

    a_rd_pending: assert property (@(posedge clk) disable iff (!arst_n) rd_pending == exp_pend)
        else begin
            err_cnt++;
            $error("FAIL rd_pending got %h expected %h", $sampled(rd_pending),
                   $sampled(exp_pend));
        end

endmodule

bind regfile_top regfile_chk u_chk (.*);

// ==== verilog/regfile_top.sv ====
`timescale 1ns/1ps

module regfile_top import regfile_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      clr,
    input  logic      ld_en,
    input  op_size_t  ld_size,
    input  reg_addr_t ld_addr,
    input  mmx_word_t ld_data,
    input  logic      dest_en,
    input  op_size_t  dest_size,
    input  reg_addr_t dest_addr,
    input  tag_t      new_tag,
    input  tag_t      done_tag,
    input  op_size_t  rd_size,
    input  reg_addr_t rd_addr,
    output mmx_word_t rd_data,
    output logic      rd_pending
);

    reg_addr_t            gpr_rd_index;
    gpr_word_t            gpr_rd_word;
    logic [GPR_SECTS-1:0] gpr_rd_pend;
    mmx_word_t            mmx_rd_word;
    logic                 mmx_rd_pend;

    gpr_bank u_gpr (
        .clk          (clk),
        .arst_n       (arst_n),
        .clr          (clr),
        .ld_en        (ld_en),
        .ld_size      (ld_size),
        .ld_addr      (ld_addr),
        .ld_data      (ld_data[GPR_W-1:0]),  // low lanes only
        .dest_en      (dest_en),
        .dest_size    (dest_size),
        .dest_addr    (dest_addr),
        .new_tag      (new_tag),
        .done_tag     (done_tag),
        .gpr_rd_index (gpr_rd_index),
        .gpr_rd_word  (gpr_rd_word),
        .gpr_rd_pend  (gpr_rd_pend)
    );

    mmx_bank u_mmx (
        .clk         (clk),
        .arst_n      (arst_n),
        .clr         (clr),
        .ld_en       (ld_en),
        .ld_size     (ld_size),
        .ld_addr     (ld_addr),
        .ld_data     (ld_data),
        .dest_en     (dest_en),
        .dest_size   (dest_size),
        .dest_addr   (dest_addr),
        .new_tag     (new_tag),
        .done_tag    (done_tag),
        .rd_addr     (rd_addr),
        .mmx_rd_word (mmx_rd_word),
        .mmx_rd_pend (mmx_rd_pend)
    );

    read_merge u_merge (
        .rd_size      (rd_size),
        .rd_addr      (rd_addr),
        .gpr_rd_word  (gpr_rd_word),
        .gpr_rd_pend  (gpr_rd_pend),
        .mmx_rd_word  (mmx_rd_word),
        .mmx_rd_pend  (mmx_rd_pend),
        .gpr_rd_index (gpr_rd_index),
        .rd_data      (rd_data),
        .rd_pending   (rd_pending)
    );

endmodule

// ==== verilog/read_merge.sv ====
`timescale 1ns/1ps

module read_merge import regfile_pkg::*; (
    input  op_size_t             rd_size,
    input  reg_addr_t            rd_addr,
    input  gpr_word_t            gpr_rd_word,
    input  logic [GPR_SECTS-1:0] gpr_rd_pend,
    input  mmx_word_t            mmx_rd_word,
    input  logic                 mmx_rd_pend,
    output reg_addr_t            gpr_rd_index,
    output mmx_word_t            rd_data,
    output logic                 rd_pending
);

    logic [7:0] byte_sel;
    logic       byte_pend;

    // byte addresses 4-7 alias the high bytes of regs 0-3
    assign gpr_rd_index = (rd_size == size_8) ? {1'b0, rd_addr[1:0]} : rd_addr;

    assign byte_sel  = rd_addr[2] ? gpr_rd_word[15:8] : gpr_rd_word[7:0];
    assign byte_pend = rd_addr[2] ? gpr_rd_pend[1] : gpr_rd_pend[0];

    always_comb begin
        case (rd_size)
            size_8: begin
                rd_data    = {{(MMX_W-8){1'b0}}, byte_sel};
                rd_pending = byte_pend;
            end
            size_16: begin
                rd_data    = {{(MMX_W-16){1'b0}}, gpr_rd_word[15:0]};
                rd_pending = |gpr_rd_pend[1:0];  // h and l
            end
            size_32: begin
                rd_data    = {{(MMX_W-GPR_W){1'b0}}, gpr_rd_word};
                rd_pending = |gpr_rd_pend;
            end
            default: begin
                rd_data    = mmx_rd_word;
                rd_pending = mmx_rd_pend;
            end
        endcase
    end

endmodule

// ==== verilog/mmx_bank.sv ====
`timescale 1ns/1ps

module mmx_bank import regfile_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      clr,
    input  logic      ld_en,
    input  op_size_t  ld_size,
    input  reg_addr_t ld_addr,
    input  mmx_word_t ld_data,
    input  logic      dest_en,
    input  op_size_t  dest_size,
    input  reg_addr_t dest_addr,
    input  tag_t      new_tag,
    input  tag_t      done_tag,
    input  reg_addr_t rd_addr,
    output mmx_word_t mmx_rd_word,
    output logic      mmx_rd_pend
);

    logic ld_hit;
    logic dest_hit;

    mmx_word_t           mm_q   [NUM_REGS];
    tag_t                tag_q  [NUM_REGS];
    logic [NUM_REGS-1:0] pend_q;

    assign ld_hit   = ld_en && (ld_size == size_64);
    assign dest_hit = dest_en && (dest_size == size_64);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_q <= '0;
            for (int r = 0; r < NUM_REGS; r++) begin
                mm_q[r]  <= '0;
                tag_q[r] <= '0;
            end
        end else if (clr) begin
            pend_q <= '0;
            for (int r = 0; r < NUM_REGS; r++) begin
                mm_q[r]  <= '0;
                tag_q[r] <= '0;
            end
        end else begin
            for (int r = 0; r < NUM_REGS; r++) begin
                if (ld_hit && ld_addr == reg_addr_t'(r)) mm_q[r] <= ld_data;
                if (dest_hit && dest_addr == reg_addr_t'(r)) begin
                    pend_q[r] <= 1'b1;
                    tag_q[r]  <= new_tag;
                end else if (tag_q[r] == done_tag) begin
                    pend_q[r] <= 1'b0;  // producer finished
                end
            end
        end
    end

    assign mmx_rd_word = mm_q[rd_addr];
    assign mmx_rd_pend = pend_q[rd_addr];

endmodule

// ==== verilog/gpr_bank.sv ====
`timescale 1ns/1ps

module gpr_bank import regfile_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 clr,
    input  logic                 ld_en,
    input  op_size_t             ld_size,
    input  reg_addr_t            ld_addr,
    input  gpr_word_t            ld_data,
    input  logic                 dest_en,
    input  op_size_t             dest_size,
    input  reg_addr_t            dest_addr,
    input  tag_t                 new_tag,
    input  tag_t                 done_tag,
    input  reg_addr_t            gpr_rd_index,
    output gpr_word_t            gpr_rd_word,
    output logic [GPR_SECTS-1:0] gpr_rd_pend
);

    // section select {e, h, l} for register idx
    function automatic logic [GPR_SECTS-1:0] sec_sel(
        input op_size_t  size,
        input reg_addr_t addr,
        input reg_addr_t idx
    );
        logic [GPR_SECTS-1:0] sel;
        sel = '0;
        case (size)
            size_8: begin
                if ({1'b0, addr[1:0]} == idx) begin
                    sel = addr[2] ? 3'b010 : 3'b001;  // high or low byte
                end
            end
            size_16: begin
                if (addr == idx) begin
                    sel = 3'b011;
                end
            end
            size_32: begin
                if (addr == idx) begin
                    sel = 3'b111;
                end
            end
            default: begin
                sel = '0;  // mmx operand
            end
        endcase
        return sel;
    endfunction

    logic [7:0] h_din;

    gpr_word_t            words [NUM_REGS];
    logic [GPR_SECTS-1:0] pends [NUM_REGS];

    // byte load into ah/bh/... comes from the low lane
    assign h_din = (ld_size == size_8) ? ld_data[7:0] : ld_data[15:8];

    for (genvar i = 0; i < NUM_REGS; i++) begin : g_reg
        logic [GPR_SECTS-1:0] ld_sel;
        logic [GPR_SECTS-1:0] dest_sel;
        logic [15:0]          e_q;
        logic [7:0]           h_q;
        logic [7:0]           l_q;
        logic [GPR_SECTS-1:0] pend_q;
        tag_t                 tag_q [GPR_SECTS];

        assign ld_sel   = ld_en ? sec_sel(ld_size, ld_addr, reg_addr_t'(i)) : '0;
        assign dest_sel = dest_en ? sec_sel(dest_size, dest_addr, reg_addr_t'(i)) : '0;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                e_q <= '0;
                h_q <= '0;
                l_q <= '0;
            end else if (clr) begin
                e_q <= '0;
                h_q <= '0;
                l_q <= '0;
            end else begin
                if (ld_sel[2]) e_q <= ld_data[31:16];
                if (ld_sel[1]) h_q <= h_din;
                if (ld_sel[0]) l_q <= ld_data[7:0];
            end
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                pend_q <= '0;
                for (int s = 0; s < GPR_SECTS; s++) begin
                    tag_q[s] <= '0;
                end
            end else if (clr) begin
                pend_q <= '0;
                for (int s = 0; s < GPR_SECTS; s++) begin
                    tag_q[s] <= '0;
                end
            end else begin
                for (int s = 0; s < GPR_SECTS; s++) begin
                    if (dest_sel[s]) begin  // new allocation beats completion
                        pend_q[s] <= 1'b1;
                        tag_q[s]  <= new_tag;
                    end else if (tag_q[s] == done_tag) begin
                        pend_q[s] <= 1'b0;
                    end
                end
            end
        end

        assign words[i] = {e_q, h_q, l_q};
        assign pends[i] = pend_q;
    end

    assign gpr_rd_word = words[gpr_rd_index];
    assign gpr_rd_pend = pends[gpr_rd_index];

endmodule

// ==== verilog/regfile_pkg.sv ====
package regfile_pkg;

    localparam int NUM_REGS  = 8;
    localparam int GPR_SECTS = 3;  // e, h, l
    localparam int TAG_W     = 7;
    localparam int GPR_W     = 32;
    localparam int MMX_W     = 64;

    typedef logic [2:0]       reg_addr_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [GPR_W-1:0] gpr_word_t;
    typedef logic [MMX_W-1:0] mmx_word_t;

    // operand size, shared by load, destination and read ports
    typedef enum logic [1:0] {
        size_8  = 2'd0,  // addr 0-3 low byte, 4-7 high byte of regs 0-3
        size_16 = 2'd1,
        size_32 = 2'd2,
        size_64 = 2'd3   // multimedia bank
    } op_size_t;

endpackage
